// ==== Bender.yml ====
package:
  name: rvPipe

sources:
  - common/rvPkg.sv
  - hw/datapath/regFile.sv
  - hw/datapath/fetchStage.sv
  - hw/datapath/decodeStage.sv
  - hw/datapath/executeStage.sv
  - hw/datapath/writebackStage.sv
  - hw/control/controlUnit.sv
  - hw/rvCore.sv
  - target: test
    files:
      - dv/rvCore_chk.sv
      - dv/rvCore_tb.sv

// ==== common/rvPkg.sv ====
/*
 * Shared widths, reset vector and encodings for the rvPipe core.
 * Opcode values follow RV32I; only the four supported major opcodes are named.
 * aluOpE leaves 4, 6 and 7 unused.
 */

package rvPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    typedef logic [xlen-1:0]     wordT;
    typedef logic [regAddrW-1:0] regAddrT;

    localparam wordT resetPc = 32'h0040_0000; // start of text segment

    typedef enum logic [6:0] {
        opLoad   = 7'd3,
        opRegImm = 7'd19,
        opStore  = 7'd35,
        opRegReg = 7'd51
    } opcodeE;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd5  // signed compare
    } aluOpE;

    typedef enum logic {
        immI = 1'b0,
        immS = 1'b1
    } immSrcE;

    // operand source for execute
    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdWb   = 2'd1,
        fwdMem  = 2'd2
    } fwdSelE;

endpackage : rvPkg

// ==== dv/rvCore_chk.sv ====
/*
 * Reset and PC rules for rvCore, bound into the core.
 * memWrite is unknown before the first reset edge, so checks start one edge in.
 */

`timescale 1ns/1ps

module rvCoreChk
    import rvPkg::*;
(
    input logic clk,
    input logic rst,
    input wordT pc,
    input logic memWrite
);

    quietInReset: assert property (@(posedge clk) rst |=> !memWrite)
        else $error("memWrite high during reset");

    quietAfterReset: assert property (@(posedge clk) $fell(rst) |-> !memWrite [*3])
        else $error("memWrite high within three cycles of reset release");

    pcAtReset: assert property (@(posedge clk) rst |=> pc == resetPc)
        else $error("pc not at reset address");

    pcStep: assert property (@(posedge clk) !rst |=> pc == $past(pc) + 32'd4)
        else $error("pc did not advance by 4");

endmodule : rvCoreChk

bind rvCore rvCoreChk chk (
    .clk      (clk),
    .rst      (rst),
    .pc       (pc),
    .memWrite (memWrite)
);

// ==== dv/rvCore_tb.sv ====
/*
 * Random program of lw/sw/ALU ops on x0..x7, checked store by store against a
 * sequential model. The generator keeps the core's limits: no use of a lw
 * destination in the next slot, and lw/sw addresses based on x0 only.
 */

`timescale 1ns/1ps

module rvCore_tb
    import rvPkg::*;
;

    localparam int          progLen    = 200;
    localparam int          imemDepth  = 256;
    localparam int          cycleLimit = progLen + 8 + 20;
    localparam logic [31:0] seed       = 32'h5e00_5c50;
    localparam wordT        nopWord    = 32'h0000_0013;  // addi x0, x0, 0

    logic clk = 1'b0;
    logic rst;
    wordT instr;
    wordT readData;
    wordT pc;
    wordT dataAddr;
    wordT writeData;
    wordT result;
    logic memWrite;

    wordT        imem [imemDepth];
    wordT        dmem [64];
    wordT        expAddr[$];
    wordT        expData[$];
    wordT        expRes [progLen];
    bit          expHasRes [progLen];
    logic [31:0] lcgState;
    int          cycles     = 0;
    int          storeSeen  = 0;
    int          resultSeen = 0;
    int          quietLeft  = 3;
    int          fetchIdx   = 0;
    int          wbIdx;
    int          errReset   = 0;
    int          errPc      = 0;
    int          errStore   = 0;
    int          errResult  = 0;
    int          errCount   = 0;
    int          total;

    rvCore uut (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .result    (result),
        .memWrite  (memWrite)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic wordT fillWord(int i);
        return wordT'(i) * 32'h9e37_79b9 + 32'h1357_9bdf;
    endfunction

    function automatic int pcIndex(wordT a);
        wordT off;
        off = a - resetPc;
        return int'(off >> 2);
    endfunction

    function automatic wordT fetchWord(wordT a);
        int idx;
        idx = pcIndex(a);
        return (idx >= 0 && idx < imemDepth) ? imem[idx] : nopWord;
    endfunction

    function automatic wordT rTypeWord(logic sub, regAddrT rs2, regAddrT rs1,
                                       logic [2:0] f3, regAddrT rd);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, opRegReg};
    endfunction

    function automatic wordT iTypeWord(logic [11:0] imm, regAddrT rs1, logic [2:0] f3,
                                       regAddrT rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic wordT sTypeWord(logic [11:0] imm, regAddrT rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], opStore};  // sw rs2, imm(x0)
    endfunction

    function automatic wordT computeAlu(logic [2:0] f3, logic sub, wordT a, wordT b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;  // never generated
        endcase
    endfunction

    function automatic void buildProgram();
        logic [31:0] r;
        logic [31:0] v;
        regAddrT     rd;
        regAddrT     rs1;
        regAddrT     rs2;
        logic [2:0]  f3;
        logic [11:0] memOff;
        regAddrT     loadRd;
        int          kind;
        bit          afterLoad;
        bit          afterStore;
        afterLoad  = 0;
        afterStore = 0;
        loadRd     = '0;
        for (int i = 0; i < imemDepth; i++) begin
            imem[i] = nopWord;
        end
        imem[0] = iTypeWord(12'hffb, 5'd0, 3'b000, 5'd1, opRegImm);
        imem[1] = iTypeWord(12'h007, 5'd1, 3'b000, 5'd0, opRegImm);  // x0 must ignore this
        imem[2] = sTypeWord(12'h004, 5'd0);   // stores zero
        imem[3] = sTypeWord(12'h008, 5'd1);
        for (int i = 4; i < progLen; i++) begin
            r      = nextRand();
            v      = nextRand();
            rd     = regAddrT'(r[10:8]);
            rs1    = regAddrT'(r[13:11]);
            rs2    = regAddrT'(r[16:14]);
            f3     = (r[19:18] == 2'd0) ? 3'b000 : (r[19:18] == 2'd1) ? 3'b010 :
                     (r[19:18] == 2'd2) ? 3'b110 : 3'b111;
            memOff = {6'd0, v[23:20], 2'b00};
            kind   = int'(r[31:28]);
            if (afterLoad && rs1 == loadRd)
                rs1 = '0;   // no load-use
            if (afterLoad && rs2 == loadRd)
                rs2 = '0;
            if ((kind == 10 || kind == 11) && afterStore)
                kind = 6;   // gap between sw and lw
            afterLoad  = 0;
            afterStore = 0;
            if (kind < 6) begin
                imem[i] = rTypeWord(r[20] && f3 == 3'b000, rs2, rs1, f3, rd);
            end else if (kind < 10) begin
                imem[i] = iTypeWord(v[31:20], rs1, f3, rd, opRegImm);
            end else if (kind < 12) begin
                imem[i]   = iTypeWord(memOff, 5'd0, 3'b010, rd, opLoad);
                afterLoad = 1;
                loadRd    = rd;
            end else if (kind < 15) begin
                imem[i]    = sTypeWord(memOff, rs2);
                afterStore = 1;
            end else begin
                imem[i] = {v[31:7], 7'h0b};  // custom-0, not decoded
            end
        end
    endfunction

    // sequential model, one instruction at a time
    function automatic void runReference();
        wordT       regs [32];
        wordT       mem [64];
        wordT       w;
        wordT       a;
        wordT       b;
        wordT       addr;
        logic [6:0] op;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = fillWord(i);
        end
        for (int i = 0; i < progLen; i++) begin
            w            = imem[i];
            op           = w[6:0];
            a            = regs[w[19:15]];
            b            = regs[w[24:20]];
            expRes[i]    = '0;
            expHasRes[i] = 1'b1;
            case (op)
                opRegReg: expRes[i] = computeAlu(w[14:12], w[30], a, b);
                opRegImm: expRes[i] = computeAlu(w[14:12], 1'b0, a,
                                                 {{20{w[31]}}, w[31:20]});
                opLoad: begin
                    addr      = a + {{20{w[31]}}, w[31:20]};
                    expRes[i] = mem[addr[7:2]];
                end
                opStore: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    mem[addr[7:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                    expHasRes[i] = 1'b0;
                end
                default: expHasRes[i] = 1'b0;
            endcase
            if (expHasRes[i])
                regs[w[11:7]] = expRes[i];
            regs[0] = '0;
        end
    endfunction

    task automatic checkWord(wordT got, wordT exp, string name, inout int errs);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    task automatic checkBit(logic got, logic exp, string name, inout int errs);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            errs++;
        end
    endtask

    task automatic checkCount(int got, int exp, string name, inout int errs);
        if (got != exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            errs++;
        end
    endtask

    // memories answer 1 ns after the edge
    always @(posedge clk) begin
        #1;
        instr    = fetchWord(pc);
        readData = dmem[dataAddr[7:2]];
    end

    always @(posedge clk) begin
        if (memWrite)
            dmem[dataAddr[7:2]] <= writeData;
    end

    always @(negedge clk) begin
        if (rst) begin
            checkWord(pc, resetPc, "pc", errReset);
            checkBit(memWrite, 1'b0, "memWrite", errReset);
            quietLeft = 3;
            fetchIdx  = 0;
        end else begin
            if (quietLeft > 0) begin
                checkBit(memWrite, 1'b0, "memWrite", errReset);
                quietLeft--;
            end
            checkWord(pc, resetPc + wordT'(fetchIdx) * 32'd4, "pc", errPc);
            wbIdx = fetchIdx - 4;   // slot now in writeback
            if (wbIdx >= 0 && wbIdx < progLen && expHasRes[wbIdx]) begin
                checkWord(result, expRes[wbIdx], "result", errResult);
                resultSeen++;
            end
            fetchIdx++;
            if (memWrite) begin
                if (storeSeen < expAddr.size()) begin
                    checkWord(dataAddr, expAddr[storeSeen], "dataAddr", errStore);
                    checkWord(writeData, expData[storeSeen], "writeData", errStore);
                end else begin
                    $display("store at %0t beyond the expected list", $time);
                    errStore++;
                end
                storeSeen++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        rst      = 1'b1;
        instr    = nopWord;
        readData = '0;
        lcgState = seed;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(i);
        end
        buildProgram();
        runReference();
        $display("program: %0d instructions, %0d stores expected", progLen, expAddr.size());
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) @(negedge clk);
        #1;
        $display("test reset      : %0d errors", errReset);
        while (pcIndex(pc) <= progLen + 4) begin
            @(negedge clk);
        end
        #1;
        checkCount(storeSeen, expAddr.size(), "store count", errCount);
        $display("test pc step    : %0d errors", errPc);
        $display("test stores     : %0d checked, %0d errors", storeSeen, errStore);
        $display("test results    : %0d checked, %0d errors", resultSeen, errResult);
        $display("test store count: %0d errors", errCount);
        total = errReset + errPc + errStore + errResult + errCount;
        $display("summary: %0d stores, %0d results, %0d errors in %0d cycles",
                 storeSeen, resultSeen, total, cycles);
        if (total == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule : rvCore_tb

// ==== hw/control/controlUnit.sv ====
/*
 * Main and ALU decode on the decode-stage instruction, then control bits
 * carried down to writeback. Unknown opcodes decode to a no-op.
 */

`timescale 1ns/1ps

module controlUnit
    import rvPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  wordT         instrD,
    output immSrcE       immSrc,
    output rvPkg::aluOpE aluOpE,
    output logic         aluSrcE,
    output logic         regWriteM,
    output logic         regWriteW,
    output logic         memWrite,
    output logic         memToRegW
);

    opcodeE       op;
    logic [2:0]   funct3;
    logic         funct7b5;

    logic         regWriteD;
    logic         memWriteD;
    logic         memToRegD;
    logic         aluSrcD;
    rvPkg::aluOpE aluOpD;

    logic         regWriteE;
    logic         memWriteE;
    logic         memToRegE;
    logic         memToRegM;

    assign op       = opcodeE'(instrD[6:0]);
    assign funct3   = instrD[14:12];
    assign funct7b5 = instrD[30];

    // main decoder
    always_comb begin
        regWriteD = 1'b0;
        memWriteD = 1'b0;
        memToRegD = 1'b0;
        aluSrcD   = 1'b0;
        immSrc    = immI;
        case (op)
            opLoad: begin
                regWriteD = 1'b1;
                memToRegD = 1'b1;
                aluSrcD   = 1'b1;
            end
            opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrc    = immS;
            end
            opRegImm: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            opRegReg: regWriteD = 1'b1;
            default: ;  // no-op
        endcase
    end

    // ALU decoder, funct7 only matters for reg-reg
    always_comb begin
        aluOpD = aluAdd;  // address calc for lw/sw
        if (op == opRegReg || op == opRegImm) begin
            case (funct3)
                3'b000:  aluOpD = (op == opRegReg && funct7b5) ? aluSub : aluAdd;
                3'b010:  aluOpD = aluSlt;
                3'b110:  aluOpD = aluOr;
                3'b111:  aluOpD = aluAnd;
                default: aluOpD = aluAdd;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            memToRegE <= 1'b0;
            aluSrcE   <= 1'b0;
            aluOpE    <= aluAdd;
            regWriteM <= 1'b0;
            memWrite  <= 1'b0;
            memToRegM <= 1'b0;
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
        end else begin
            regWriteE <= regWriteD;   // execute
            memWriteE <= memWriteD;
            memToRegE <= memToRegD;
            aluSrcE   <= aluSrcD;
            aluOpE    <= aluOpD;
            regWriteM <= regWriteE;   // memory
            memWrite  <= memWriteE;
            memToRegM <= memToRegE;
            regWriteW <= regWriteM;   // writeback
            memToRegW <= memToRegM;
        end
    end

endmodule : controlUnit

// ==== hw/datapath/decodeStage.sv ====
/*
 * Register read and I/S immediate extension, registered into execute.
 * Writeback lands on the falling edge so same-cycle reads see it.
 */

`timescale 1ns/1ps

module decodeStage
    import rvPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  wordT    instrD,
    input  immSrcE  immSrc,
    input  logic    regWriteW,
    input  regAddrT rdW,
    input  wordT    resultW,
    output regAddrT rs1E,
    output regAddrT rs2E,
    output regAddrT rdE,
    output wordT    rd1E,
    output wordT    rd2E,
    output wordT    immE
);

    regAddrT rs1D;
    regAddrT rs2D;
    wordT    rd1D;
    wordT    rd2D;
    wordT    immD;

    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];

    regFile regs (
        .clk (clk),
        .rst (rst),
        .we  (regWriteW),
        .ra1 (rs1D),
        .ra2 (rs2D),
        .wa  (rdW),
        .wd  (resultW),
        .rd1 (rd1D),
        .rd2 (rd2D)
    );

    always_comb begin
        case (immSrc)
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            default: immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rs1E <= '0;
            rs2E <= '0;
            rdE  <= '0;
            rd1E <= '0;
            rd2E <= '0;
            immE <= '0;
        end else begin
            rs1E <= rs1D;
            rs2E <= rs2D;
            rdE  <= instrD[11:7];
            rd1E <= rd1D;
            rd2E <= rd2D;
            immE <= immD;
        end
    end

endmodule : decodeStage

// ==== hw/datapath/executeStage.sv ====
/*
 * Forwarding from memory (preferred) and writeback, operand select, ALU.
 * A lw result is only forwardable from writeback; see the load-use limit.
 */

`timescale 1ns/1ps

module executeStage
    import rvPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  regAddrT      rs1E,
    input  regAddrT      rs2E,
    input  regAddrT      rdE,
    input  wordT         rd1E,
    input  wordT         rd2E,
    input  wordT         immE,
    input  rvPkg::aluOpE aluOpE,
    input  logic         aluSrcE,
    input  logic         regWriteM,
    input  logic         regWriteW,
    input  regAddrT      rdW,
    input  wordT         resultW,
    output wordT         aluResultM,
    output wordT         writeDataM,
    output regAddrT      rdM
);

    fwdSelE fwdA;
    fwdSelE fwdB;
    wordT   srcA;
    wordT   srcB;
    wordT   writeDataE;
    wordT   aluResultE;

    function automatic fwdSelE pickFwd(regAddrT rs);
        if (rs != '0 && regWriteM && rs == rdM) begin
            return fwdMem;
        end else if (rs != '0 && regWriteW && rs == rdW) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    function automatic wordT fwdMux(fwdSelE sel, wordT regVal);
        case (sel)
            fwdMem:  return aluResultM;
            fwdWb:   return resultW;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        fwdA       = pickFwd(rs1E);
        fwdB       = pickFwd(rs2E);
        srcA       = fwdMux(fwdA, rd1E);
        writeDataE = fwdMux(fwdB, rd2E);
    end

    assign srcB = aluSrcE ? immE : writeDataE;

    always_comb begin
        case (aluOpE)
            aluSub:  aluResultE = srcA - srcB;
            aluAnd:  aluResultE = srcA & srcB;
            aluOr:   aluResultE = srcA | srcB;
            aluSlt:  aluResultE = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            default: aluResultE = srcA + srcB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aluResultM <= '0;
            writeDataM <= '0;
            rdM        <= '0;
        end else begin
            aluResultM <= aluResultE;
            writeDataM <= writeDataE;
            rdM        <= rdE;
        end
    end

endmodule : executeStage

// ==== hw/datapath/fetchStage.sv ====
/*
 * PC starts at resetPc and steps by 4 every cycle; there is no redirect.
 */

`timescale 1ns/1ps

module fetchStage
    import rvPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  wordT instr,
    output wordT pc,
    output wordT instrD,
    output wordT pcD
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= resetPc;
            instrD <= '0;  // all-zero word decodes as no-op
            pcD    <= '0;
        end else begin
            pc     <= pc + 32'd4;
            instrD <= instr;
            pcD    <= pc;
        end
    end

endmodule : fetchStage

// ==== hw/datapath/regFile.sv ====
/*
 * 32 x 32 register file, written on the falling clock edge.
 * x0 always reads as zero whatever was written to it.
 */

`timescale 1ns/1ps

module regFile
    import rvPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    we,
    input  regAddrT ra1,
    input  regAddrT ra2,
    input  regAddrT wa,
    input  wordT    wd,
    output wordT    rd1,
    output wordT    rd2
);

    wordT regs [32];

    always_ff @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule : regFile

// ==== hw/datapath/writebackStage.sv ====
/*
 * Memory/writeback register and final result select.
 * readData is sampled in the same cycle the address is presented.
 */

`timescale 1ns/1ps

module writebackStage
    import rvPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  wordT    aluResultM,
    input  wordT    readData,
    input  regAddrT rdM,
    input  logic    memToRegW,
    output wordT    resultW,
    output regAddrT rdW
);

    wordT aluResultW;
    wordT readDataW;

    always_ff @(posedge clk) begin
        if (rst) begin
            aluResultW <= '0;
            readDataW  <= '0;
            rdW        <= '0;
        end else begin
            aluResultW <= aluResultM;
            readDataW  <= readData;
            rdW        <= rdM;
        end
    end

    assign resultW = memToRegW ? readDataW : aluResultW;  // load data or ALU

endmodule : writebackStage

// ==== hw/rvCore.sv ====
/*
 * Five-stage RV32I subset core: lw, sw, add/sub/and/or/slt (reg and imm).
 * No branches, no jumps and no load-use stall; the program must not read
 * a lw destination in the very next instruction. Memories answer in the same cycle.
 */

`timescale 1ns/1ps

module rvCore
    import rvPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  wordT instr,
    input  wordT readData,
    output wordT pc,
    output wordT dataAddr,
    output wordT writeData,
    output wordT result,
    output logic memWrite
);

    wordT          instrD;
    immSrcE        immSrc;
    rvPkg::aluOpE  aluOpE;
    logic          aluSrcE;
    logic          regWriteM;
    logic          regWriteW;
    logic          memToRegW;
    regAddrT       rs1E;
    regAddrT       rs2E;
    regAddrT       rdE;
    regAddrT       rdM;
    regAddrT       rdW;
    wordT          rd1E;
    wordT          rd2E;
    wordT          immE;

    controlUnit ctrl (
        .clk       (clk),
        .rst       (rst),
        .instrD    (instrD),
        .immSrc    (immSrc),
        .aluOpE    (aluOpE),
        .aluSrcE   (aluSrcE),
        .regWriteM (regWriteM),
        .regWriteW (regWriteW),
        .memWrite  (memWrite),
        .memToRegW (memToRegW)
    );

    fetchStage fetch (
        .clk    (clk),
        .rst    (rst),
        .instr  (instr),
        .pc     (pc),
        .instrD (instrD),
        .pcD    ()         // no consumer without branches
    );

    decodeStage decode (
        .clk       (clk),
        .rst       (rst),
        .instrD    (instrD),
        .immSrc    (immSrc),
        .regWriteW (regWriteW),
        .rdW       (rdW),
        .resultW   (result),
        .rs1E      (rs1E),
        .rs2E      (rs2E),
        .rdE       (rdE),
        .rd1E      (rd1E),
        .rd2E      (rd2E),
        .immE      (immE)
    );

    executeStage execute (
        .clk        (clk),
        .rst        (rst),
        .rs1E       (rs1E),
        .rs2E       (rs2E),
        .rdE        (rdE),
        .rd1E       (rd1E),
        .rd2E       (rd2E),
        .immE       (immE),
        .aluOpE     (aluOpE),
        .aluSrcE    (aluSrcE),
        .regWriteM  (regWriteM),
        .regWriteW  (regWriteW),
        .rdW        (rdW),
        .resultW    (result),
        .aluResultM (dataAddr),
        .writeDataM (writeData),
        .rdM        (rdM)
    );

    writebackStage writeback (
        .clk        (clk),
        .rst        (rst),
        .aluResultM (dataAddr),
        .readData   (readData),
        .rdM        (rdM),
        .memToRegW  (memToRegW),
        .resultW    (result),
        .rdW        (rdW)
    );

endmodule : rvCore

// ==== rvPipe.f ====
common/rvPkg.sv
hw/datapath/regFile.sv
hw/datapath/fetchStage.sv
hw/datapath/decodeStage.sv
hw/datapath/executeStage.sv
hw/datapath/writebackStage.sv
hw/control/controlUnit.sv
hw/rvCore.sv
dv/rvCore_chk.sv
dv/rvCore_tb.sv
